// File: source/mem_bus_pkg.sv
package mem_bus_pkg;

	// AXI encodings used by the single-beat data path
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;
	localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
	localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

	// CPU data bus request, sampled while stall is low
	typedef struct packed {
		logic        read;
		logic        write;
		logic [31:0] address;
		logic [31:0] wrdata;
	} dbus_req_t;

	// CPU data bus response
	typedef struct packed {
		logic        stall;
		logic [31:0] rddata;
	} dbus_resp_t;

	// Master-driven AXI signals, IDs travel separately
	typedef struct packed {
		// Read address channel
		logic [31:0] araddr;
		logic        arvalid;
		logic [3:0]  arlen;
		logic [2:0]  arsize;
		logic [1:0]  arburst;
		// Write address channel
		logic [31:0] awaddr;
		logic        awvalid;
		logic [3:0]  awlen;
		logic [2:0]  awsize;
		logic [1:0]  awburst;
		// Write data channel
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wlast;
		logic        wvalid;
		// Response channel readies
		logic        rready;
		logic        bready;
	} axi_req_t;

	// Slave-driven AXI signals, IDs travel separately
	typedef struct packed {
		logic        arready;
		logic        awready;
		logic        wready;
		// Read data channel
		logic        rvalid;
		logic [31:0] rdata;
		logic        rlast;
		// Write response channel
		logic        bvalid;
		logic [1:0]  bresp;
	} axi_resp_t;

endpackage

// File: source/dcache_pass.sv
`timescale 1ns/1ps

module dcache_pass #(
	parameter int ID_WIDTH = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	// CPU data bus
	input  mem_bus_pkg::dbus_req_t  dbus_req,
	output mem_bus_pkg::dbus_resp_t dbus_resp,
	// AXI master side
	output mem_bus_pkg::axi_req_t   axi_req,
	output logic [ID_WIDTH - 1:0]   axi_req_arid,
	output logic [ID_WIDTH - 1:0]   axi_req_awid,
	output logic [ID_WIDTH - 1:0]   axi_req_wid,
	input  mem_bus_pkg::axi_resp_t  axi_resp,
	input  logic [ID_WIDTH - 1:0]   axi_resp_rid,
	input  logic [ID_WIDTH - 1:0]   axi_resp_bid
);
	import mem_bus_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		READ_ADDR,
		READ_DATA,
		WRITE_ADDR,
		WRITE_DATA,
		FINISHED
	} state_t;

	state_t state;
	state_t state_d;

	// Captured CPU request
	logic        pipe_read;
	logic        pipe_write;
	logic [31:0] pipe_addr;
	logic [31:0] pipe_wdata;

	logic [31:0] rddata;
	logic        stall;
	logic        rd_done;
	logic        wr_done;

	// Final handshakes of each access
	assign rd_done = (state == READ_DATA) && axi_resp.rvalid;
	assign wr_done = (state == WRITE_DATA) && axi_resp.wready;

	// High from the cycle after capture until FINISHED
	always_comb begin
		if (state == IDLE) begin
			stall = pipe_read || pipe_write;
		end else begin
			stall = (state != FINISHED);
		end
	end

	always_comb begin
		dbus_resp.stall  = stall;
		dbus_resp.rddata = rddata;
	end

	// Single ID of zero as only one transaction is in flight
	assign axi_req_arid = '0;
	assign axi_req_awid = '0;
	assign axi_req_wid  = '0;

	always_comb begin
		state_d = state;
		case (state)
			IDLE: begin
				// Read wins when both strobes were high
				if (pipe_read) begin
					state_d = READ_ADDR;
				end else if (pipe_write) begin
					state_d = WRITE_ADDR;
				end
			end
			READ_ADDR: begin
				if (axi_resp.arready) begin
					state_d = READ_DATA;
				end
			end
			READ_DATA: begin
				if (axi_resp.rvalid) begin
					state_d = FINISHED;
				end
			end
			WRITE_ADDR: begin
				if (axi_resp.awready) begin
					state_d = WRITE_DATA;
				end
			end
			WRITE_DATA: begin
				if (axi_resp.wready) begin
					state_d = FINISHED;
				end
			end
			FINISHED: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// Single beat of one word with every byte enabled
	always_comb begin
		axi_req         = '0;
		axi_req.araddr  = pipe_addr;
		axi_req.arlen   = '0;
		axi_req.arsize  = AXI_SIZE_WORD;
		axi_req.arburst = AXI_BURST_INCR;
		axi_req.awaddr  = pipe_addr;
		axi_req.awlen   = '0;
		axi_req.awsize  = AXI_SIZE_WORD;
		axi_req.awburst = AXI_BURST_INCR;
		axi_req.wdata   = pipe_wdata;
		axi_req.wstrb   = '1;
		// Write responses are consumed and dropped
		axi_req.bready  = 1'b1;
		case (state)
			READ_ADDR:  axi_req.arvalid = 1'b1;
			READ_DATA:  axi_req.rready  = 1'b1;
			WRITE_ADDR: axi_req.awvalid = 1'b1;
			WRITE_DATA: begin
				axi_req.wvalid = 1'b1;
				axi_req.wlast  = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_read  <= 1'b0;
			pipe_write <= 1'b0;
		end else if (!stall) begin
			pipe_read  <= dbus_req.read;
			pipe_write <= dbus_req.write;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pipe_addr  <= dbus_req.address;
			pipe_wdata <= dbus_req.wrdata;
		end
	end

	// Read word, or the written word echoed back
	always_ff @(posedge clk) begin
		if (rst) begin
			rddata <= '0;
		end else if (rd_done) begin
			rddata <= axi_resp.rdata;
		end else if (wr_done) begin
			rddata <= pipe_wdata;
		end
	end

	// Slave must echo the zero ID on a single-beat read
	a_read_id: assert property (@(posedge clk) disable iff (rst)
		axi_resp.rvalid |-> (axi_resp_rid == '0) && axi_resp.rlast);

	a_write_resp: assert property (@(posedge clk) disable iff (rst)
		axi_resp.bvalid |-> (axi_resp_bid == '0) && (axi_resp.bresp == AXI_RESP_OKAY));

endmodule

// File: source/axi_sram.sv
`timescale 1ns/1ps

module axi_sram #(
	parameter int ID_WIDTH    = 4,
	parameter int DEPTH       = 256,
	parameter int WAIT_CYCLES = 2
) (
	input  logic                   clk,
	input  logic                   rst,
	input  mem_bus_pkg::axi_req_t  axi_req,
	input  logic [ID_WIDTH - 1:0]  axi_req_arid,
	input  logic [ID_WIDTH - 1:0]  axi_req_awid,
	input  logic [ID_WIDTH - 1:0]  axi_req_wid,
	output mem_bus_pkg::axi_resp_t axi_resp,
	output logic [ID_WIDTH - 1:0]  axi_resp_rid,
	output logic [ID_WIDTH - 1:0]  axi_resp_bid
);
	import mem_bus_pkg::*;

	// DEPTH is a power of two so upper address bits simply wrap
	localparam int ADDR_W = $clog2(DEPTH);
	localparam int CNT_W  = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

	logic [31:0] mem [DEPTH];

	logic [CNT_W - 1:0]    wait_cnt;
	logic                  arready;
	logic                  awready;
	logic                  rvalid;
	logic                  bvalid;
	logic                  wr_pending;
	logic [ADDR_W - 1:0]   wr_idx;
	logic [ID_WIDTH - 1:0] rd_id;
	logic [ID_WIDTH - 1:0] wr_id;
	logic [31:0]           rd_data;
	logic                  idle;
	logic                  wready;
	logic                  ar_fire;
	logic                  aw_fire;
	logic                  w_fire;

	// No transaction anywhere in progress
	assign idle    = !(arready || awready || rvalid || wr_pending || bvalid);
	assign ar_fire = axi_req.arvalid && arready;
	assign aw_fire = axi_req.awvalid && awready;
	assign wready  = wr_pending && axi_req.wvalid;
	assign w_fire  = axi_req.wvalid && wready;

	always_comb begin
		axi_resp.arready = arready;
		axi_resp.awready = awready;
		axi_resp.wready  = wready;
		axi_resp.rvalid  = rvalid;
		axi_resp.rdata   = rd_data;
		axi_resp.rlast   = rvalid;
		axi_resp.bvalid  = bvalid;
		axi_resp.bresp   = AXI_RESP_OKAY;
	end

	assign axi_resp_rid = rd_id;
	assign axi_resp_bid = wr_id;

	// Count WAIT_CYCLES then pulse one address ready
	always_ff @(posedge clk) begin
		if (rst) begin
			wait_cnt <= '0;
			arready  <= 1'b0;
			awready  <= 1'b0;
		end else begin
			arready <= 1'b0;
			awready <= 1'b0;
			if (idle && (axi_req.arvalid || axi_req.awvalid)) begin
				if (wait_cnt == CNT_W'(WAIT_CYCLES)) begin
					wait_cnt <= '0;
					// Reads go first on a tie
					if (axi_req.arvalid) begin
						arready <= 1'b1;
					end else begin
						awready <= 1'b1;
					end
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (rvalid && axi_req.rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rd_data <= mem[axi_req.araddr[2 +: ADDR_W]];
			rd_id   <= axi_req_arid;
		end
	end

	// Write address accepted, waiting for its single data beat
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_pending <= 1'b0;
			bvalid     <= 1'b0;
		end else begin
			if (aw_fire) begin
				wr_pending <= 1'b1;
			end else if (w_fire) begin
				wr_pending <= 1'b0;
			end
			if (w_fire) begin
				bvalid <= 1'b1;
			end else if (axi_req.bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			wr_idx <= axi_req.awaddr[2 +: ADDR_W];
			wr_id  <= axi_req_awid;
		end
	end

	always_ff @(posedge clk) begin
		if (w_fire) begin
			mem[wr_idx] <= axi_req.wdata;
		end
	end

	a_ar_single_beat: assert property (@(posedge clk) disable iff (rst)
		axi_req.arvalid |-> (axi_req.arlen == '0) && (axi_req.arburst == AXI_BURST_INCR)
			&& (axi_req.arsize == AXI_SIZE_WORD));

	a_aw_single_beat: assert property (@(posedge clk) disable iff (rst)
		axi_req.awvalid |-> (axi_req.awlen == '0) && (axi_req.awburst == AXI_BURST_INCR)
			&& (axi_req.awsize == AXI_SIZE_WORD));

	a_full_word_write: assert property (@(posedge clk) disable iff (rst)
		axi_req.wvalid |-> (axi_req.wstrb == '1) && axi_req.wlast);

	// Data beat only after its address, carrying the same ID
	a_w_follows_aw: assert property (@(posedge clk) disable iff (rst)
		axi_req.wvalid |-> wr_pending && (axi_req_wid == wr_id));

endmodule

// File: source/mem_path_top.sv
`timescale 1ns/1ps

module mem_path_top #(
	parameter int ID_WIDTH    = 4,
	parameter int DEPTH       = 256,
	parameter int WAIT_CYCLES = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  mem_bus_pkg::dbus_req_t  dbus_req,
	output mem_bus_pkg::dbus_resp_t dbus_resp
);
	import mem_bus_pkg::*;

	// AXI link between the bridge and the memory
	axi_req_t              axi_req;
	axi_resp_t             axi_resp;
	logic [ID_WIDTH - 1:0] arid;
	logic [ID_WIDTH - 1:0] awid;
	logic [ID_WIDTH - 1:0] wid;
	logic [ID_WIDTH - 1:0] rid;
	logic [ID_WIDTH - 1:0] bid;

	dcache_pass #(
		.ID_WIDTH(ID_WIDTH)
	) u_dcache_pass (
		.clk          (clk),
		.rst          (rst),
		.dbus_req     (dbus_req),
		.dbus_resp    (dbus_resp),
		.axi_req      (axi_req),
		.axi_req_arid (arid),
		.axi_req_awid (awid),
		.axi_req_wid  (wid),
		.axi_resp     (axi_resp),
		.axi_resp_rid (rid),
		.axi_resp_bid (bid)
	);

	axi_sram #(
		.ID_WIDTH   (ID_WIDTH),
		.DEPTH      (DEPTH),
		.WAIT_CYCLES(WAIT_CYCLES)
	) u_axi_sram (
		.clk          (clk),
		.rst          (rst),
		.axi_req      (axi_req),
		.axi_req_arid (arid),
		.axi_req_awid (awid),
		.axi_req_wid  (wid),
		.axi_resp     (axi_resp),
		.axi_resp_rid (rid),
		.axi_resp_bid (bid)
	);

endmodule

// File: bench/tb_mem_path.sv
`timescale 1ns/1ps

module tb_mem_path;
	import mem_bus_pkg::*;

	localparam int DEPTH      = 64;
	localparam int IDX_W      = $clog2(DEPTH);
	localparam int TIMEOUT    = 200;
	localparam int RANDOM_OPS = 200;

	logic       clk;
	logic       rst;
	dbus_req_t  dbus_req;
	dbus_resp_t dbus_resp;

	// Reference memory, wraps modulo DEPTH words like the SRAM
	logic [31:0] model [DEPTH];
	logic        known [DEPTH];

	int checks;
	int errors;
	int tests;
	int failed_tests;
	int test_errors;
	bit hung;

	mem_path_top #(
		.DEPTH(DEPTH)
	) u_mem_path_top (
		.clk      (clk),
		.rst      (rst),
		.dbus_req (dbus_req),
		.dbus_resp(dbus_resp)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [IDX_W - 1:0] model_index(input logic [31:0] word);
		return word[IDX_W - 1:0];
	endfunction

	task automatic compare_value(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("FAIL %s %s expected %08h actual %08h", name, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (test_errors == 0) begin
			$display("test %s passed", name);
		end else begin
			failed_tests++;
			$display("test %s failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// Entered and left on a falling edge with stall low
	task automatic run_access(input string name, input logic rd, input logic wr,
			input logic [31:0] addr, input logic [31:0] data);
		int cycles;
		dbus_req.read    = rd;
		dbus_req.write   = wr;
		dbus_req.address = addr;
		dbus_req.wrdata  = data;
		@(posedge clk);
		@(negedge clk);
		// Captured once, then the bus goes quiet
		dbus_req = '0;
		compare_value(name, "stall after capture", 32'd1, 32'(dbus_resp.stall));
		cycles = 0;
		while (dbus_resp.stall && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		assert (!dbus_resp.stall) else begin
			$display("Test %s hung, stall stayed high for %0d cycles", name, TIMEOUT);
			hung = 1'b1;
			errors++;
			test_errors++;
		end
	endtask

	task automatic write_word(input string name, input logic [31:0] word,
			input logic [31:0] data);
		run_access(name, 1'b0, 1'b1, {word[29:0], 2'b00}, data);
		if (!hung) begin
			model[model_index(word)] = data;
			known[model_index(word)] = 1'b1;
			compare_value(name, "write echo", data, dbus_resp.rddata);
		end
	endtask

	task automatic read_word(input string name, input logic [31:0] word);
		run_access(name, 1'b1, 1'b0, {word[29:0], 2'b00}, 32'h0);
		if (!hung) begin
			compare_value(name, "read data", model[model_index(word)], dbus_resp.rddata);
		end
	endtask

	task automatic reset_state();
		compare_value("reset_state", "stall", 32'd0, 32'(dbus_resp.stall));
		compare_value("reset_state", "rddata", 32'd0, dbus_resp.rddata);
		end_test("reset_state");
	endtask

	task automatic write_read_back();
		write_word("write_read_back", 32'd3, 32'hA5C3_0F1E);
		read_word("write_read_back", 32'd3);
		end_test("write_read_back");
	endtask

	task automatic write_echo();
		write_word("write_echo", 32'd17, 32'h1357_9BDF);
		// rddata holds until the next access completes
		repeat (3) @(negedge clk);
		compare_value("write_echo", "held rddata", 32'h1357_9BDF, dbus_resp.rddata);
		end_test("write_echo");
	endtask

	task automatic random_traffic();
		logic [31:0] word;
		for (int i = 0; i < RANDOM_OPS && !hung; i++) begin
			word = $urandom % DEPTH;
			if ($urandom % 2 == 1) begin
				write_word("random_traffic", word, $urandom);
			end else begin
				// Never read a word the model does not know yet
				if (!known[model_index(word)]) begin
					write_word("random_traffic", word, $urandom);
				end
				read_word("random_traffic", word);
			end
		end
		end_test("random_traffic");
	endtask

	task automatic address_aliasing();
		write_word("address_aliasing", 32'(5 + DEPTH), 32'hC0DE_0005);
		read_word("address_aliasing", 32'd5);
		if (!hung) begin
			compare_value("address_aliasing", "aliased word", 32'hC0DE_0005, dbus_resp.rddata);
		end
		end_test("address_aliasing");
	endtask

	task automatic read_precedence();
		write_word("read_precedence", 32'd9, 32'h2468_ACE0);
		// Both strobes high, only the read may happen
		run_access("read_precedence", 1'b1, 1'b1, 32'd9 << 2, 32'hFFFF_0000);
		if (!hung) begin
			compare_value("read_precedence", "read data", 32'h2468_ACE0, dbus_resp.rddata);
		end
		read_word("read_precedence", 32'd9);
		end_test("read_precedence");
	endtask

	initial begin
		void'($urandom(45));
		rst          = 1'b1;
		dbus_req     = '0;
		checks       = 0;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		test_errors  = 0;
		hung         = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			model[i] = '0;
			known[i] = 1'b0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		reset_state();
		if (!hung) write_read_back();
		if (!hung) write_echo();
		if (!hung) random_traffic();
		if (!hung) address_aliasing();
		if (!hung) read_precedence();

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
source/mem_bus_pkg.sv
source/dcache_pass.sv
source/axi_sram.sv
source/mem_path_top.sv
bench/tb_mem_path.sv

// File: Makefile
# Verilator build and run for the memory path testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_path
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi; \
	if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
